// File: ddr_test_consts.svh
// ddr3 exerciser constants
// bus widths, burst shape, test size, pattern seed and led timing
`ifndef DDR_TEST_CONSTS_SVH
`define DDR_TEST_CONSTS_SVH

// ******************************
// data path widths
`define DDR_WORD_W      16               // stream word
`define DDR_BEAT_W      64               // four words per axi beat
`define DDR_ADDR_W      28               // byte address

// ******************************
// burst and test size
`define DDR_BURST_LEN   8                // beats per burst
`define DDR_TEST_WORDS  256              // multiple of 32
`define DDR_BASE_ADDR   28'h0100000      // first byte address
`define DDR_PAT_SEED    16'hA5C3         // xored with word index

// ******************************
// misc
`define DDR_LED_BLINK   16               // cycles per error led toggle
`define DDR_FIFO_DEPTH  32               // entries per fifo

`endif

// File: ddr_test_pkg.sv
// ddr3 exerciser types
// vector typedefs, fsm states and axi channel payload structs
`include "ddr_test_consts.svh"

package ddr_test_pkg;

   typedef logic [`DDR_WORD_W-1:0] word_t;
   typedef logic [`DDR_BEAT_W-1:0] beat_t;
   typedef logic [`DDR_ADDR_W-1:0] addr_t;
   typedef logic [9:0]             wcount_t;   // up to 1023 words

   // checker fsm
   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_WRITE,
      GEN_READ,
      GEN_DONE
   } gen_state_t;

   // axi sequencer fsm
   typedef enum logic [2:0] {
      AXI_IDLE,
      AXI_WR_ADDR,
      AXI_WR_DATA,
      AXI_RD_ADDR,
      AXI_RD_DATA
   } axi_state_t;

   // write and read address payload
   typedef struct packed {
      addr_t      addr;
      logic [3:0] len;    // beats minus one
   } axi_aw_t;

   typedef struct packed {
      beat_t data;
      logic  last;
   } axi_w_t;

   typedef struct packed {
      beat_t data;
      logic  last;
   } axi_r_t;

endpackage

// File: ddr_stream_fifo.sv
// ddr stream fifo
// single clock first-word-fall-through buffer with occupancy count
`timescale 1ns/1ps

module ddr_stream_fifo #(
   parameter int WIDTH = 16,
   parameter int DEPTH = 32
) (
   input  logic                         sys_clk,
   input  logic                         arst_n,
   input  logic                         push,
   input  logic [WIDTH-1:0]             push_data,
   input  logic                         pop,
   output logic [WIDTH-1:0]             pop_data,
   output logic                         full,
   output logic                         empty,
   output logic [$clog2(DEPTH+1)-1:0]   count
);

   localparam int PW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH+1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PW-1:0]    wr_ptr;
   logic [PW-1:0]    rd_ptr;

   // wraps for any depth
   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
      return (p == PW'(DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   assign pop_data = mem[rd_ptr];     // fall through
   assign full     = (count == CW'(DEPTH));
   assign empty    = (count == '0);

   always_ff @(posedge sys_clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ******************************
   // overflow and underflow guards
   a_no_overflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
      full |-> !push);
   a_no_underflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
      empty |-> !pop);

endmodule

// File: ddr_data_gen_chk.sv
// pattern writer and read-back checker
// writes index xor seed, reads it back and flags any mismatch
`timescale 1ns/1ps
`include "ddr_test_consts.svh"

module ddr_data_gen_chk (
   input  logic                sys_clk,
   input  logic                arst_n,
   input  logic                init_done,
   input  logic                wr_full,
   input  logic                rd_empty,
   input  ddr_test_pkg::word_t rd_data,
   output logic                wr_en,
   output ddr_test_pkg::word_t wr_data,
   output logic                rd_en,
   output logic                phase_read,
   output logic                error_flag,
   output logic                test_done
);

   localparam int LAST_IDX = `DDR_TEST_WORDS - 1;

   ddr_test_pkg::gen_state_t state;
   ddr_test_pkg::wcount_t    idx;          // shared by both phases
   ddr_test_pkg::word_t      expect_word;

   assign expect_word = ddr_test_pkg::word_t'(idx) ^ ddr_test_pkg::word_t'(`DDR_PAT_SEED);

   // ******************************
   // stream side
   assign wr_data    = expect_word;
   assign wr_en      = (state == ddr_test_pkg::GEN_WRITE) && !wr_full;
   assign rd_en      = (state == ddr_test_pkg::GEN_READ) && !rd_empty;
   assign phase_read = (state == ddr_test_pkg::GEN_READ);
   assign test_done  = (state == ddr_test_pkg::GEN_DONE);

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= ddr_test_pkg::GEN_IDLE;
         idx        <= '0;
         error_flag <= 1'b0;
      end else begin
         unique case (state)
            ddr_test_pkg::GEN_IDLE: begin
               idx <= '0;
               if (init_done) state <= ddr_test_pkg::GEN_WRITE;
            end
            ddr_test_pkg::GEN_WRITE: begin
               if (wr_en) begin
                  if (idx == ddr_test_pkg::wcount_t'(LAST_IDX)) begin
                     idx   <= '0;
                     state <= ddr_test_pkg::GEN_READ;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            ddr_test_pkg::GEN_READ: begin
               if (rd_en) begin
                  if (rd_data != expect_word) error_flag <= 1'b1;   // sticky
                  if (idx == ddr_test_pkg::wcount_t'(LAST_IDX)) begin
                     state <= ddr_test_pkg::GEN_DONE;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            default: ;                                              // done holds
         endcase
      end
   end

   // ******************************
   // nothing comes back from memory before the read phase
   a_no_early_read: assert property (@(posedge sys_clk) disable iff (!arst_n)
      (state == ddr_test_pkg::GEN_WRITE) |-> rd_empty && !rd_en);

endmodule

// File: axi_burst_master.sv
// axi burst master
// packs words into 64-bit beats and runs one 8-beat burst at a time
`timescale 1ns/1ps
`include "ddr_test_consts.svh"

module axi_burst_master (
   input  logic                    sys_clk,
   input  logic                    arst_n,
   input  logic                    init_done,
   input  logic                    phase_read,
   input  logic                    wr_en,
   input  ddr_test_pkg::word_t     wr_data,
   input  logic                    rd_en,
   input  logic                    aw_ready,
   input  logic                    w_ready,
   input  logic                    ar_ready,
   input  ddr_test_pkg::axi_r_t    r,
   input  logic                    r_valid,
   output logic                    wr_full,
   output ddr_test_pkg::word_t     rd_data,
   output logic                    rd_empty,
   output ddr_test_pkg::axi_aw_t   aw,
   output logic                    aw_valid,
   output ddr_test_pkg::axi_w_t    w,
   output logic                    w_valid,
   output ddr_test_pkg::axi_aw_t   ar,
   output logic                    ar_valid
);

   localparam int WPB         = `DDR_BEAT_W / `DDR_WORD_W;       // words per beat
   localparam int SW          = $clog2(WPB);
   localparam int BURST_WORDS = WPB * `DDR_BURST_LEN;
   localparam int BURST_BYTES = `DDR_BURST_LEN * `DDR_BEAT_W / 8;
   localparam int N_BURSTS    = `DDR_TEST_WORDS / BURST_WORDS;
   localparam int BCW         = $clog2(N_BURSTS+1);
   localparam int CW          = $clog2(`DDR_FIFO_DEPTH+1);

   ddr_test_pkg::axi_state_t state;
   ddr_test_pkg::beat_t      beat_q;      // beat under assembly
   ddr_test_pkg::word_t      wr_pop_data;
   ddr_test_pkg::beat_t      rd_beat;     // holding beat at read fifo head
   logic [SW-1:0]            pack_sel;
   logic [SW-1:0]            rd_sel;
   logic [2:0]               beat_cnt;
   logic [3:0]               w_beats;     // beats accepted since the last aw
   logic [BCW-1:0]           wr_burst;
   logic [BCW-1:0]           rd_burst;
   logic [CW-1:0]            wr_count;
   logic [CW-1:0]            rd_count;
   logic                     wr_empty;
   logic                     wr_pop;
   logic                     rd_pop;

   function automatic ddr_test_pkg::addr_t burst_addr(input logic [BCW-1:0] k);
      return ddr_test_pkg::addr_t'(`DDR_BASE_ADDR) +
             (ddr_test_pkg::addr_t'(k) << $clog2(BURST_BYTES));
   endfunction

   // ******************************
   // buffers
   ddr_stream_fifo #(.WIDTH(`DDR_WORD_W), .DEPTH(`DDR_FIFO_DEPTH)) i_wr_fifo (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .push      (wr_en),
      .push_data (wr_data),
      .pop       (wr_pop),
      .pop_data  (wr_pop_data),
      .full      (wr_full),
      .empty     (wr_empty),
      .count     (wr_count)
   );

   ddr_stream_fifo #(.WIDTH(`DDR_BEAT_W), .DEPTH(`DDR_FIFO_DEPTH)) i_rd_fifo (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .push      (r_valid),              // r has no ready
      .push_data (r.data),
      .pop       (rd_pop),
      .pop_data  (rd_beat),
      .full      (),
      .empty     (rd_empty),
      .count     (rd_count)
   );

   assign wr_pop  = (state == ddr_test_pkg::AXI_WR_DATA) && !w_valid && !wr_empty;
   assign rd_data = rd_beat[rd_sel*`DDR_WORD_W +: `DDR_WORD_W];
   assign rd_pop  = rd_en && (rd_sel == SW'(WPB-1));     // last word of the beat

   assign aw_valid = (state == ddr_test_pkg::AXI_WR_ADDR);
   assign ar_valid = (state == ddr_test_pkg::AXI_RD_ADDR);
   assign aw       = '{addr: burst_addr(wr_burst), len: 4'(`DDR_BURST_LEN-1)};
   assign ar       = '{addr: burst_addr(rd_burst), len: 4'(`DDR_BURST_LEN-1)};
   assign w        = '{data: beat_q, last: (beat_cnt == 3'(`DDR_BURST_LEN-1))};

   always_ff @(posedge sys_clk) begin
      if (wr_pop) beat_q[pack_sel*`DDR_WORD_W +: `DDR_WORD_W] <= wr_pop_data;
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_sel <= '0;
      end else if (rd_en) begin
         rd_sel <= rd_sel + 1'b1;
      end
   end

   // ******************************
   // burst sequencer
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ddr_test_pkg::AXI_IDLE;
         pack_sel <= '0;
         beat_cnt <= '0;
         w_valid  <= 1'b0;
         wr_burst <= '0;
         rd_burst <= '0;
      end else begin
         unique case (state)
            ddr_test_pkg::AXI_IDLE: begin
               if (init_done && wr_burst != BCW'(N_BURSTS) &&
                   wr_count >= CW'(BURST_WORDS)) begin
                  state <= ddr_test_pkg::AXI_WR_ADDR;
               end else if (init_done && phase_read && wr_burst == BCW'(N_BURSTS) &&
                            rd_burst != BCW'(N_BURSTS) &&
                            rd_count <= CW'(`DDR_FIFO_DEPTH - `DDR_BURST_LEN)) begin
                  state <= ddr_test_pkg::AXI_RD_ADDR;
               end
            end
            ddr_test_pkg::AXI_WR_ADDR: if (aw_ready) state <= ddr_test_pkg::AXI_WR_DATA;
            ddr_test_pkg::AXI_WR_DATA: begin
               if (wr_pop) begin
                  pack_sel <= pack_sel + 1'b1;
                  if (pack_sel == SW'(WPB-1)) w_valid <= 1'b1;   // beat complete
               end
               if (w_valid && w_ready) begin
                  w_valid  <= 1'b0;
                  beat_cnt <= beat_cnt + 1'b1;
                  if (w.last) begin
                     wr_burst <= wr_burst + 1'b1;
                     state    <= ddr_test_pkg::AXI_IDLE;
                  end
               end
            end
            ddr_test_pkg::AXI_RD_ADDR: if (ar_ready) state <= ddr_test_pkg::AXI_RD_DATA;
            ddr_test_pkg::AXI_RD_DATA: begin
               if (r_valid && r.last) begin
                  rd_burst <= rd_burst + 1'b1;
                  state    <= ddr_test_pkg::AXI_IDLE;
               end
            end
            default: state <= ddr_test_pkg::AXI_IDLE;
         endcase
      end
   end

   // ******************************
   // channel rules
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         w_beats <= '0;
      end else if (aw_valid && aw_ready) begin
         w_beats <= '0;
      end else if (w_valid && w_ready) begin
         w_beats <= w_beats + 1'b1;
      end
   end

   a_aw_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw));
   a_w_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      w_valid && !w_ready |=> w_valid && $stable(w));
   a_ar_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar));
   // last only on the 8th beat after the address
   a_w_last: assert property (@(posedge sys_clk) disable iff (!arst_n)
      w_valid |-> w.last == (w_beats == 4'(`DDR_BURST_LEN-1)));

endmodule

// File: led_disp.sv
// status leds
// steady init-done led and a blinking error led
`timescale 1ns/1ps
`include "ddr_test_consts.svh"

module led_disp (
   input  logic sys_clk,
   input  logic arst_n,
   input  logic init_done,
   input  logic error_flag,
   output logic led_init_done,
   output logic led_error
);

   localparam int CW = $clog2(`DDR_LED_BLINK);

   logic [CW-1:0] blink_cnt;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         led_init_done <= 1'b0;
         led_error     <= 1'b0;
         blink_cnt     <= '0;
      end else begin
         led_init_done <= init_done;               // one cycle late
         if (!error_flag) begin
            blink_cnt <= '0;
            led_error <= 1'b0;
         end else if (blink_cnt == CW'(`DDR_LED_BLINK-1)) begin
            blink_cnt <= '0;
            led_error <= ~led_error;               // half period done
         end else begin
            blink_cnt <= blink_cnt + 1'b1;
         end
      end
   end

endmodule

// File: ddr_test_top.sv
// ddr3 exerciser top level
// checker, axi burst master and status leds on one clock
`timescale 1ns/1ps

module ddr_test_top (
   input  logic                    sys_clk,
   input  logic                    arst_n,
   input  logic                    init_done,
   input  logic                    aw_ready,
   input  logic                    w_ready,
   input  logic                    ar_ready,
   input  ddr_test_pkg::axi_r_t    r,
   input  logic                    r_valid,
   output ddr_test_pkg::axi_aw_t   aw,
   output logic                    aw_valid,
   output ddr_test_pkg::axi_w_t    w,
   output logic                    w_valid,
   output ddr_test_pkg::axi_aw_t   ar,
   output logic                    ar_valid,
   output logic                    test_done,
   output logic                    error_flag,
   output logic                    led_init_done,
   output logic                    led_error
);

   // ******************************
   // stream between checker and master
   logic                wr_en;
   ddr_test_pkg::word_t wr_data;
   logic                wr_full;
   logic                rd_en;
   ddr_test_pkg::word_t rd_data;
   logic                rd_empty;
   logic                phase_read;

   ddr_data_gen_chk i_gen_chk (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .init_done  (init_done),
      .wr_full    (wr_full),
      .rd_empty   (rd_empty),
      .rd_data    (rd_data),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .rd_en      (rd_en),
      .phase_read (phase_read),
      .error_flag (error_flag),
      .test_done  (test_done)
   );

   axi_burst_master i_master (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .init_done  (init_done),
      .phase_read (phase_read),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .rd_en      (rd_en),
      .aw_ready   (aw_ready),
      .w_ready    (w_ready),
      .ar_ready   (ar_ready),
      .r          (r),
      .r_valid    (r_valid),
      .wr_full    (wr_full),
      .rd_data    (rd_data),
      .rd_empty   (rd_empty),
      .aw         (aw),
      .aw_valid   (aw_valid),
      .w          (w),
      .w_valid    (w_valid),
      .ar         (ar),
      .ar_valid   (ar_valid)
   );

   led_disp i_led (
      .sys_clk       (sys_clk),
      .arst_n        (arst_n),
      .init_done     (init_done),
      .error_flag    (error_flag),
      .led_init_done (led_init_done),
      .led_error     (led_error)
   );

endmodule

// File: tb_axi_mem.sv
// axi memory model for the ddr3 exerciser testbench
// beat store with random ready, random read gaps and an optional bit flip
`timescale 1ns/1ps

module tb_axi_mem #(
   parameter int MAX_STALL = 3
) (
   input  logic                  sys_clk,
   input  logic                  arst_n,
   input  logic                  corrupt,
   input  ddr_test_pkg::axi_aw_t aw,
   input  logic                  aw_valid,
   input  ddr_test_pkg::axi_w_t  w,
   input  logic                  w_valid,
   input  ddr_test_pkg::axi_aw_t ar,
   input  logic                  ar_valid,
   output logic                  aw_ready,
   output logic                  w_ready,
   output logic                  ar_ready,
   output ddr_test_pkg::axi_r_t  r,
   output logic                  r_valid
);

   ddr_test_pkg::beat_t   mem [int unsigned];   // keyed by beat address
   ddr_test_pkg::axi_aw_t aw_q;
   ddr_test_pkg::axi_aw_t ar_q;
   ddr_test_pkg::axi_w_t  w_q;
   ddr_test_pkg::axi_r_t  r_q = '0;
   logic                  aw_fire;
   logic                  w_fire;
   logic                  ar_fire;
   logic                  aw_rdy = 1'b0;
   logic                  w_rdy = 1'b0;
   logic                  ar_rdy = 1'b0;
   logic                  r_vld = 1'b0;
   int unsigned           lcg_state = 42;
   int unsigned           wr_ptr;
   int unsigned           rd_ptr;
   int                    stored;               // beats written since reset
   int                    rd_left;
   int                    aw_stall, w_stall, ar_stall, r_gap;

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // ready about half the time, never low longer than MAX_STALL cycles
   task automatic step_ready(inout int stall, output logic rdy);
      int unsigned rnd;
      rnd   = lcg_next();
      rdy   = (stall >= MAX_STALL) || rnd[20];
      stall = rdy ? 0 : stall + 1;
   endtask

   assign aw_ready = aw_rdy;
   assign w_ready  = w_rdy;
   assign ar_ready = ar_rdy;
   assign r        = r_q;
   assign r_valid  = r_vld;

   // ******************************
   // handshakes seen on the rising edge
   always @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_fire <= 1'b0;
         w_fire  <= 1'b0;
         ar_fire <= 1'b0;
      end else begin
         aw_fire <= aw_valid && aw_rdy;
         w_fire  <= w_valid && w_rdy;
         ar_fire <= ar_valid && ar_rdy;
         aw_q    <= aw;
         w_q     <= w;
         ar_q    <= ar;
      end
   end

   // ******************************
   // store, fetch and drive on the falling edge
   always @(negedge sys_clk or negedge arst_n) begin
      logic                rdy;
      ddr_test_pkg::beat_t data;
      if (!arst_n) begin
         mem.delete();
         stored   = 0;
         rd_left  = 0;
         aw_stall = 0;
         w_stall  = 0;
         ar_stall = 0;
         r_gap    = 0;
         aw_rdy   <= 1'b0;
         w_rdy    <= 1'b0;
         ar_rdy   <= 1'b0;
         r_vld    <= 1'b0;
      end else begin
         if (aw_fire) wr_ptr = 32'(aw_q.addr >> 3);
         if (w_fire) begin
            data = w_q.data;
            if (corrupt && stored == 4) data[0] = ~data[0];    // fifth beat
            mem[wr_ptr] = data;
            wr_ptr++;
            stored++;
         end
         if (ar_fire) begin
            rd_ptr  = 32'(ar_q.addr >> 3);
            rd_left = int'(ar_q.len) + 1;
         end
         step_ready(aw_stall, rdy);
         aw_rdy <= rdy;
         step_ready(w_stall, rdy);
         w_rdy <= rdy;
         step_ready(ar_stall, rdy);
         ar_rdy <= rdy;
         r_vld <= 1'b0;
         if (rd_left > 0) begin
            step_ready(r_gap, rdy);                             // random gap
            if (rdy) begin
               r_q   <= '{data: mem.exists(rd_ptr) ? mem[rd_ptr] : '0, last: rd_left == 1};
               r_vld <= 1'b1;
               rd_ptr++;
               rd_left--;
            end
         end
      end
   end

endmodule

// File: tb_ddr_test.sv
// ddr3 exerciser testbench
// two passes against the axi memory model, checked by concurrent assertions
`timescale 1ns/1ps
`include "ddr_test_consts.svh"

module tb_ddr_test;

   localparam int MAX_STALL   = 3;
   localparam int N_BEATS     = `DDR_TEST_WORDS * `DDR_WORD_W / `DDR_BEAT_W;
   localparam int N_BURSTS    = N_BEATS / `DDR_BURST_LEN;
   localparam int BURST_BYTES = `DDR_BURST_LEN * `DDR_BEAT_W / 8;
   localparam int IDLE_CYC    = 10;
   localparam int TAIL_CYC    = 8 * `DDR_LED_BLINK;
   // every word written and read at the worst stall, two passes, 4x margin
   localparam int TIMEOUT_CYC = 4 * 2 * (2 * `DDR_TEST_WORDS * (MAX_STALL + 2) + 2 * TAIL_CYC);

   logic                  sys_clk;
   logic                  arst_n;
   logic                  init_done;
   logic                  corrupt;
   logic                  aw_ready, w_ready, ar_ready, r_valid;
   logic                  aw_valid, w_valid, ar_valid;
   logic                  test_done, error_flag, led_init_done, led_error;
   ddr_test_pkg::axi_aw_t aw;
   ddr_test_pkg::axi_aw_t ar;
   ddr_test_pkg::axi_w_t  w;
   ddr_test_pkg::axi_r_t  r;
   int                    error_count = 0;
   int                    aw_cnt, w_cnt, ar_cnt, r_cnt;   // handshakes since reset
   int                    err_cyc;                        // cycles with error_flag high
   int                    total_w, total_r;

   ddr_test_top i_dut (
      .sys_clk(sys_clk), .arst_n(arst_n), .init_done(init_done),
      .aw_ready(aw_ready), .w_ready(w_ready), .ar_ready(ar_ready),
      .r(r), .r_valid(r_valid), .aw(aw), .aw_valid(aw_valid),
      .w(w), .w_valid(w_valid), .ar(ar), .ar_valid(ar_valid),
      .test_done(test_done), .error_flag(error_flag),
      .led_init_done(led_init_done), .led_error(led_error)
   );

   tb_axi_mem #(.MAX_STALL(MAX_STALL)) i_mem (
      .sys_clk(sys_clk), .arst_n(arst_n), .corrupt(corrupt),
      .aw(aw), .aw_valid(aw_valid), .w(w), .w_valid(w_valid),
      .ar(ar), .ar_valid(ar_valid), .aw_ready(aw_ready), .w_ready(w_ready),
      .ar_ready(ar_ready), .r(r), .r_valid(r_valid)
   );

   always #4 sys_clk = ~sys_clk;

   function automatic ddr_test_pkg::word_t pattern_word(input int i);
      return ddr_test_pkg::word_t'(i) ^ `DDR_PAT_SEED;
   endfunction

   // beat j carries words 4j..4j+3, word 0 in the low bits
   function automatic ddr_test_pkg::beat_t beat_of(input int j);
      ddr_test_pkg::beat_t b;
      for (int n = 0; n < 4; n++) b[n*16 +: 16] = pattern_word(4*j + n);
      return b;
   endfunction

   function automatic ddr_test_pkg::addr_t burst_addr_of(input int k);
      return ddr_test_pkg::addr_t'(`DDR_BASE_ADDR + BURST_BYTES * k);
   endfunction

   function automatic void count_error(input string msg);
      error_count++;
      $display("** Error at %0t: %s", $time, msg);
   endfunction

   always @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_cnt  <= 0;
         w_cnt   <= 0;
         ar_cnt  <= 0;
         r_cnt   <= 0;
         err_cyc <= 0;
      end else begin
         if (aw_valid && aw_ready) aw_cnt <= aw_cnt + 1;
         if (w_valid && w_ready)   w_cnt  <= w_cnt + 1;
         if (ar_valid && ar_ready) ar_cnt <= ar_cnt + 1;
         if (r_valid)              r_cnt  <= r_cnt + 1;
         err_cyc <= error_flag ? err_cyc + 1 : 0;
      end
   end

   // ******************************
   // reset state and init led
   a_quiet: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !init_done |-> !aw_valid && !w_valid && !ar_valid && !test_done && !error_flag && !led_error)
      else count_error("output active before init_done");
   a_led_init: assert property (@(posedge sys_clk) disable iff (!arst_n)
      led_init_done == $past(init_done)) else count_error("led_init_done lag wrong");

   // ******************************
   // write bursts
   a_aw_addr: assert property (@(posedge sys_clk) disable iff (!arst_n)
      aw_valid |-> aw_cnt < N_BURSTS && w_cnt == aw_cnt * `DDR_BURST_LEN &&
                   aw.addr == burst_addr_of(aw_cnt) && aw.len == 4'(`DDR_BURST_LEN - 1))
      else count_error("write address or len wrong");
   a_w_order: assert property (@(posedge sys_clk) disable iff (!arst_n)
      w_valid |-> w_cnt < aw_cnt * `DDR_BURST_LEN) else count_error("w beat without address");
   a_w_data: assert property (@(posedge sys_clk) disable iff (!arst_n)
      w_valid |-> w.data == beat_of(w_cnt)) else count_error("write beat data wrong");
   a_w_last: assert property (@(posedge sys_clk) disable iff (!arst_n)
      w_valid |-> w.last == (w_cnt % `DDR_BURST_LEN == `DDR_BURST_LEN - 1))
      else count_error("w last misplaced");

   // ******************************
   // back-pressure holds channel state
   a_aw_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else count_error("aw not held");
   a_w_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      w_valid && !w_ready |=> w_valid && $stable(w)) else count_error("w not held");
   a_ar_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar)) else count_error("ar not held");

   // ******************************
   // read bursts and result flags
   a_ar_addr: assert property (@(posedge sys_clk) disable iff (!arst_n)
      ar_valid |-> w_cnt == N_BEATS && r_cnt == ar_cnt * `DDR_BURST_LEN &&
                   ar.addr == burst_addr_of(ar_cnt) && ar.len == 4'(`DDR_BURST_LEN - 1))
      else count_error("read address differs from write address");
   a_clean: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !corrupt |-> !error_flag) else count_error("error_flag set on clean data");
   a_err_sticky: assert property (@(posedge sys_clk) disable iff (!arst_n)
      error_flag |=> error_flag) else count_error("error_flag dropped");
   a_err_cause: assert property (@(posedge sys_clk) disable iff (!arst_n)
      $rose(error_flag) |-> corrupt && r_cnt > 4) else count_error("error_flag rose too early");
   a_done: assert property (@(posedge sys_clk) disable iff (!arst_n)
      $rose(test_done) |-> ar_cnt == N_BURSTS && r_cnt == N_BEATS && error_flag == corrupt)
      else count_error("test_done with wrong burst count or error state");
   a_done_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      test_done |=> test_done) else count_error("test_done dropped");
   a_led_blink: assert property (@(posedge sys_clk) disable iff (!arst_n)
      error_flag |-> led_error == ((err_cyc / `DDR_LED_BLINK) % 2 == 1))
      else count_error("led_error blink phase wrong");
   a_led_off: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !error_flag |-> !led_error) else count_error("led_error lit without error");

   task automatic run_pass(input logic corrupt_on);
      @(negedge sys_clk);
      arst_n    = 1'b0;
      init_done = 1'b0;
      corrupt   = corrupt_on;
      repeat (3) @(negedge sys_clk);
      arst_n = 1'b1;
      repeat (IDLE_CYC) @(negedge sys_clk);      // outputs must stay low
      init_done = 1'b1;
      while (!test_done) @(negedge sys_clk);
      repeat (TAIL_CYC) @(negedge sys_clk);      // room for led toggles
      total_w += w_cnt;
      total_r += r_cnt;
   endtask

   initial begin : watchdog
      repeat (TIMEOUT_CYC) @(posedge sys_clk);
      $display("watchdog expired after %0d cycles, test_done did not arrive", TIMEOUT_CYC);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      sys_clk   = 1'b0;
      arst_n    = 1'b0;
      init_done = 1'b0;
      corrupt   = 1'b0;
      total_w   = 0;
      total_r   = 0;
      run_pass(1'b0);
      run_pass(1'b1);
      $display("summary: 2 runs, %0d write beats, %0d read beats, %0d errors",
               total_w, total_r, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+.
ddr_test_pkg.sv
ddr_stream_fifo.sv
ddr_data_gen_chk.sv
axi_burst_master.sv
led_disp.sv
ddr_test_top.sv
tb_axi_mem.sv
tb_ddr_test.sv

// File: Makefile
# Verilator build and run of the ddr3 exerciser testbench
VERILATOR ?= verilator
TOP       ?= tb_ddr_test
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST)) ddr_test_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx 'TEST OK' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
